// File: hw/servo_pkg.sv
package servo_pkg;

    localparam int DATA_W  = 32;
    localparam int SHIFT_W = 5;
    localparam int ADDR_W  = 5;

    // ################################################
    // Register map.
    // ################################################
    localparam logic [ADDR_W-1:0] ADDR_MODE  = 5'h00;
    localparam logic [ADDR_W-1:0] ADDR_GAIN  = 5'h04;
    localparam logic [ADDR_W-1:0] ADDR_CONST = 5'h08;
    localparam logic [ADDR_W-1:0] ADDR_SETPT = 5'h0C;

    localparam logic [SHIFT_W-1:0] GAIN_RST = 5'd5;

    // Actuator travel of +/- 2^20.
    localparam logic signed [DATA_W-1:0] POS_MAX = 32'sd1048576;
    localparam logic signed [DATA_W-1:0] POS_MIN = -32'sd1048576;

    typedef enum logic [1:0] {
        MODE_OFF   = 2'd0,
        MODE_FB    = 2'd1,
        MODE_CONST = 2'd2,
        MODE_RSVD  = 2'd3   // Treated as off.
    } loop_mode_e;

    typedef enum logic [1:0] {
        ST_IDLE, ST_ACC, ST_APPLY, ST_UPDATE
    } seq_state_e;

endpackage

// File: hw/servo_seq_if.sv
interface servo_seq_if;
    import servo_pkg::*;

    loop_mode_e                 mode;
    logic [SHIFT_W-1:0]         shift;
    logic signed [DATA_W-1:0]   const_step;
    logic                       trig;       // High in ST_ACC.
    logic                       trig_dly;   // High in ST_APPLY.
    logic                       act_en;     // High in ST_UPDATE.

    modport ctrl (
        output mode, shift, const_step,
        output trig, trig_dly, act_en
    );

    modport step (
        input mode, shift, const_step,
        input trig, trig_dly
    );

    modport act (
        input act_en
    );

endinterface

// File: hw/servo_ctrl.sv
module servo_ctrl (
    input  logic                               i_clk,
    input  logic                               i_rst_n,
    input  logic                               i_psel,
    input  logic                               i_penable,
    input  logic                               i_pwrite,
    input  logic [servo_pkg::ADDR_W-1:0]       i_paddr,
    input  logic [servo_pkg::DATA_W-1:0]       i_pwdata,
    output logic [servo_pkg::DATA_W-1:0]       o_prdata,
    output logic                               o_pready,
    input  logic                               i_sample,
    output logic signed [servo_pkg::DATA_W-1:0] o_setpt,
    output logic                               o_busy,
    output logic                               o_done,
    servo_seq_if.ctrl                          seq
);
    import servo_pkg::*;

    loop_mode_e                 mode_q;
    logic [SHIFT_W-1:0]         gain_q;
    logic signed [DATA_W-1:0]   const_q;
    logic signed [DATA_W-1:0]   setpt_q;
    logic                       wr_en;

    seq_state_e                 state;
    seq_state_e                 state_nxt;
    logic                       done_q;

    // ################################################
    // APB registers.
    // ################################################
    assign wr_en    = i_psel && i_penable && i_pwrite;
    assign o_pready = 1'b1;   // Zero wait states.

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            mode_q  <= MODE_OFF;
            gain_q  <= GAIN_RST;
            const_q <= '0;
            setpt_q <= '0;
        end else if (wr_en) begin
            case (i_paddr)
                ADDR_MODE:  mode_q  <= loop_mode_e'(i_pwdata[1:0]);
                ADDR_GAIN:  gain_q  <= i_pwdata[SHIFT_W-1:0];
                ADDR_CONST: const_q <= i_pwdata;
                ADDR_SETPT: setpt_q <= i_pwdata;
                default: ;
            endcase
        end
    end

    always_comb begin
        case (i_paddr)
            ADDR_MODE:  o_prdata = {{(DATA_W-2){1'b0}}, mode_q};
            ADDR_GAIN:  o_prdata = {{(DATA_W-SHIFT_W){1'b0}}, gain_q};
            ADDR_CONST: o_prdata = const_q;
            ADDR_SETPT: o_prdata = setpt_q;
            default:    o_prdata = '0;   // Unmapped.
        endcase
    end

    // ################################################
    // Pass sequencer.
    // ################################################
    always_comb begin
        case (state)
            ST_IDLE:   state_nxt = i_sample ? ST_ACC : ST_IDLE;
            ST_ACC:    state_nxt = ST_APPLY;
            ST_APPLY:  state_nxt = ST_UPDATE;
            default:   state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state  <= ST_IDLE;
            done_q <= 1'b0;
        end else begin
            state  <= state_nxt;
            done_q <= (state == ST_UPDATE);   // One cycle after the update edge.
        end
    end

    assign o_busy  = (state != ST_IDLE);
    assign o_done  = done_q;
    assign o_setpt = setpt_q;

    assign seq.mode       = mode_q;
    assign seq.shift      = gain_q;
    assign seq.const_step = const_q;
    assign seq.trig       = (state == ST_ACC);
    assign seq.trig_dly   = (state == ST_APPLY);
    assign seq.act_en     = (state == ST_UPDATE);

endmodule

// File: hw/servo_err.sv
module servo_err (
    input  logic                                i_clk,
    input  logic                                i_rst_n,
    input  logic                                i_sample,
    input  logic signed [servo_pkg::DATA_W-1:0] i_setpt,
    input  logic signed [servo_pkg::DATA_W-1:0] i_meas,
    output logic signed [servo_pkg::DATA_W-1:0] o_err
);
    import servo_pkg::*;

    logic signed [DATA_W:0]   diff;
    logic signed [DATA_W-1:0] diff_sat;
    logic signed [DATA_W-1:0] err_q;

    // One extra bit so the subtraction cannot wrap.
    assign diff = {i_setpt[DATA_W-1], i_setpt} - {i_meas[DATA_W-1], i_meas};

    always_comb begin
        if (diff[DATA_W] != diff[DATA_W-1]) begin
            // On overflow pin to the rail of the true sign.
            diff_sat = diff[DATA_W] ? {1'b1, {(DATA_W-1){1'b0}}}
                                    : {1'b0, {(DATA_W-1){1'b1}}};
        end else begin
            diff_sat = diff[DATA_W-1:0];
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            err_q <= '0;
        end else if (i_sample) begin
            err_q <= diff_sat;
        end
    end

    assign o_err = err_q;

endmodule

// File: hw/servo_step_gen.sv
module servo_step_gen (
    input  logic                                i_clk,
    input  logic                                i_rst_n,
    input  logic signed [servo_pkg::DATA_W-1:0] i_err,
    output logic signed [servo_pkg::DATA_W-1:0] o_step,
    servo_seq_if.step                           seq
);
    import servo_pkg::*;

    logic signed [DATA_W-1:0] pre_step;
    logic signed [DATA_W-1:0] step_q;
    logic signed [DATA_W-1:0] pre_sum;
    logic signed [DATA_W-1:0] pre_scaled;

    // ################################################
    // Accumulate and scale.
    // ################################################
    assign pre_sum    = pre_step + i_err;            // Wraps.
    assign pre_scaled = pre_step >>> seq.shift;      // Gain as a power of two.

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pre_step <= '0;
            step_q   <= '0;
        end else begin
            case (seq.mode)
                MODE_FB: begin
                    if (seq.trig) begin
                        pre_step <= pre_sum;
                    end else if (seq.trig_dly) begin
                        step_q <= pre_scaled;
                    end
                end
                MODE_CONST: begin
                    // Pre-step is left alone here.
                    if (seq.trig) begin
                        step_q <= seq.const_step;
                    end
                end
                MODE_OFF, MODE_RSVD: begin
                    pre_step <= '0;
                    step_q   <= '0;
                end
            endcase
        end
    end

    assign o_step = step_q;

endmodule

// File: hw/servo_actuator.sv
module servo_actuator (
    input  logic                                i_clk,
    input  logic                                i_rst_n,
    input  logic signed [servo_pkg::DATA_W-1:0] i_step,
    output logic signed [servo_pkg::DATA_W-1:0] o_pos,
    servo_seq_if.act                            act
);
    import servo_pkg::*;

    logic signed [DATA_W-1:0] pos_q;
    logic signed [DATA_W:0]   sum;
    logic signed [DATA_W-1:0] pos_nxt;

    // Sum one bit wider and clamp it to the travel range.
    assign sum = {pos_q[DATA_W-1], pos_q} + {i_step[DATA_W-1], i_step};

    always_comb begin
        if (sum > POS_MAX) begin
            pos_nxt = POS_MAX;
        end else if (sum < POS_MIN) begin
            pos_nxt = POS_MIN;
        end else begin
            pos_nxt = sum[DATA_W-1:0];
        end
    end

    // ################################################
    // Position register.
    // ################################################
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pos_q <= '0;
        end else if (act.act_en) begin
            pos_q <= pos_nxt;
        end
    end

    assign o_pos = pos_q;   // Holds while the loop is off.

endmodule

// File: hw/servo_top.sv
module servo_top (
    input  logic                                i_clk,
    input  logic                                i_rst_n,
    input  logic                                i_psel,
    input  logic                                i_penable,
    input  logic                                i_pwrite,
    input  logic [servo_pkg::ADDR_W-1:0]        i_paddr,
    input  logic [servo_pkg::DATA_W-1:0]        i_pwdata,
    output logic [servo_pkg::DATA_W-1:0]        o_prdata,
    output logic                                o_pready,
    input  logic                                i_sample,
    input  logic signed [servo_pkg::DATA_W-1:0] i_meas,
    output logic signed [servo_pkg::DATA_W-1:0] o_step,
    output logic signed [servo_pkg::DATA_W-1:0] o_pos,
    output logic                                o_busy,
    output logic                                o_done
);

    logic signed [servo_pkg::DATA_W-1:0] setpt;
    logic signed [servo_pkg::DATA_W-1:0] err;

    servo_seq_if seq_if ();

    servo_ctrl ctrl_i (
        .i_clk, .i_rst_n,
        .i_psel, .i_penable, .i_pwrite, .i_paddr, .i_pwdata,
        .o_prdata, .o_pready,
        .i_sample,
        .o_setpt (setpt),
        .o_busy, .o_done,
        .seq     (seq_if.ctrl)
    );

    servo_err err_i (
        .i_clk, .i_rst_n, .i_sample,
        .i_setpt (setpt),
        .i_meas,
        .o_err   (err)
    );

    servo_step_gen step_gen_i (
        .i_clk, .i_rst_n,
        .i_err  (err),
        .o_step,
        .seq    (seq_if.step)
    );

    servo_actuator actuator_i (
        .i_clk, .i_rst_n,
        .i_step (o_step),
        .o_pos,
        .act    (seq_if.act)
    );

endmodule

// File: dv/servo_clk_gen.sv
module servo_clk_gen (
    output logic o_clk,
    output logic o_rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        o_clk = 1'b0;
        forever #2 o_clk = ~o_clk;   // 4 ns period.
    end

    initial begin
        o_rst_n <= 1'b0;
        repeat (2) @(posedge o_clk);
        o_rst_n <= 1'b1;
    end

endmodule

// File: dv/servo_checker.sv
module servo_checker (
    input  logic                                i_clk,
    input  logic                                i_rst_n,
    input  logic                                i_psel,
    input  logic                                i_penable,
    input  logic                                i_pwrite,
    input  logic [servo_pkg::ADDR_W-1:0]        i_paddr,
    input  logic [servo_pkg::DATA_W-1:0]        i_pwdata,
    input  logic                                i_sample,
    input  logic signed [servo_pkg::DATA_W-1:0] i_meas,
    input  logic signed [servo_pkg::DATA_W-1:0] i_step,
    input  logic signed [servo_pkg::DATA_W-1:0] i_pos,
    input  logic                                i_busy,
    input  logic                                i_done,
    output int                                  o_n_ok,
    output int                                  o_n_err
);
    timeunit 1ns;
    timeprecision 100ps;
    import servo_pkg::*;

    localparam longint LMAX = 64'sh7fff_ffff;
    localparam longint LMIN = -LMAX - 1;

    logic [1:0] m_mode;
    int         m_gain;
    int         m_const;
    int         m_setpt;
    int         m_pre;
    int         m_step;
    int         m_pos;
    bit         pend;
    int         cyc;

    function automatic int sat_diff(input int a, input int b);
        longint d;
        d = longint'(a) - longint'(b);
        if (d > LMAX) return int'(LMAX);
        if (d < LMIN) return int'(LMIN);
        return int'(d);
    endfunction

    function automatic int clamp_pos(input int p, input int s);
        longint t;
        t = longint'(p) + longint'(s);
        if (t > longint'(POS_MAX)) return int'(POS_MAX);
        if (t < longint'(POS_MIN)) return int'(POS_MIN);
        return int'(t);
    endfunction

    // ################################################
    // Model and compare.
    // ################################################
    always @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            m_mode = MODE_OFF;
            m_gain = int'(GAIN_RST);
            m_const = 0;
            m_setpt = 0;
            m_pre = 0;
            m_step = 0;
            m_pos = 0;
            pend = 1'b0;
            cyc = 0;
            o_n_ok = 0;
            o_n_err = 0;
        end else begin
            if (pend) cyc = cyc + 1;
            if (i_done) begin
                if (!pend) begin
                    $display("error at %0t: o_done pulsed with no pass in flight", $time);
                    o_n_err = o_n_err + 1;
                end else begin
                    if (cyc != 4) begin
                        $display("error at %0t: o_done came %0d cycles after the sample, not 4",
                                 $time, cyc);
                        o_n_err = o_n_err + 1;
                    end
                    if (i_step !== m_step) begin
                        $display("mismatch at %0t: o_step expected %0d actual %0d",
                                 $time, m_step, i_step);
                        o_n_err = o_n_err + 1;
                    end else if (i_pos !== m_pos) begin
                        $display("mismatch at %0t: o_pos expected %0d actual %0d",
                                 $time, m_pos, i_pos);
                        o_n_err = o_n_err + 1;
                    end else begin
                        o_n_ok = o_n_ok + 1;
                    end
                    pend = 1'b0;
                end
            end else if (pend && cyc >= 4) begin
                $display("error at %0t: o_done never came after the sample", $time);
                o_n_err = o_n_err + 1;
                pend = 1'b0;
            end
            if (i_busy !== pend) begin
                $display("mismatch at %0t: o_busy expected %0b actual %0b", $time, pend, i_busy);
                o_n_err = o_n_err + 1;
            end
            if (i_psel && i_penable && i_pwrite) begin
                case (i_paddr)
                    ADDR_MODE: begin
                        m_mode = i_pwdata[1:0];
                        if (m_mode != MODE_FB && m_mode != MODE_CONST) begin
                            m_pre = 0;   // Off clears the loop state.
                            m_step = 0;
                        end
                    end
                    ADDR_GAIN:  m_gain = int'(i_pwdata[SHIFT_W-1:0]);
                    ADDR_CONST: m_const = i_pwdata;
                    ADDR_SETPT: m_setpt = i_pwdata;
                    default: ;
                endcase
            end
            if (i_sample && !pend) begin
                if (m_mode == MODE_FB) begin
                    m_pre = m_pre + sat_diff(m_setpt, i_meas);
                    m_step = m_pre >>> m_gain;
                end else if (m_mode == MODE_CONST) begin
                    m_step = m_const;
                end else begin
                    m_pre = 0;
                    m_step = 0;
                end
                m_pos = clamp_pos(m_pos, m_step);
                pend = 1'b1;
                cyc = 0;
            end
        end
    end

endmodule

// File: dv/servo_tb.sv
module servo_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import servo_pkg::*;

    localparam int CLK_NS = 4;
    localparam int NR = 27;
    localparam int WDOG_CYC = NR * 40 + 200;

    typedef struct packed {
        loop_mode_e         mode;
        logic [SHIFT_W-1:0] gain;
        logic [31:0]        cst;
        logic [31:0]        setpt;
        logic [31:0]        meas;
        logic               wr;    // Write the configuration first.
        logic               rnd;   // LCG measurement checked by the model only.
        logic               dbl;   // Extra sample while busy.
        logic [31:0]        exp_step;
        logic [31:0]        exp_pos;
    } row_t;

    // ################################################
    // Stimulus table.
    // ################################################
    localparam row_t ROWS [NR] = '{
        '{MODE_FB,    5'd2,  32'd0, 32'd100, 32'd0,   1'b1, 1'b0, 1'b0, 32'd25, 32'd25},
        '{MODE_FB,    5'd2,  32'd0, 32'd100, 32'd20,  1'b0, 1'b0, 1'b1, 32'd45, 32'd70},
        '{MODE_FB,    5'd2,  32'd0, 32'd100, 32'd300, 1'b0, 1'b0, 1'b0, -32'sd5, 32'd65},
        '{MODE_FB,    5'd0,  32'd0, 32'd100, 32'd110, 1'b1, 1'b0, 1'b0, -32'sd30, 32'd35},
        '{MODE_FB,    5'd4,  32'd0, 32'd100, 32'd100, 1'b1, 1'b0, 1'b0, -32'sd2, 32'd33},
        '{MODE_OFF,   5'd4,  32'd0, 32'd100, 32'd0,   1'b1, 1'b0, 1'b0, 32'd0, 32'd33},
        '{MODE_FB,    5'd1,  32'd0, 32'd10,  32'd0,   1'b1, 1'b0, 1'b0, 32'd5, 32'd38},
        '{MODE_CONST, 5'd1,  32'd300000, 32'd10, 32'd0, 1'b1, 1'b0, 1'b0, 32'd300000, 32'd300038},
        '{MODE_CONST, 5'd1,  32'd300000, 32'd10, 32'd0, 1'b0, 1'b0, 1'b0, 32'd300000, 32'd600038},
        '{MODE_CONST, 5'd1,  32'd300000, 32'd10, 32'd0, 1'b0, 1'b0, 1'b0, 32'd300000, 32'd900038},
        '{MODE_CONST, 5'd1,  32'd300000, 32'd10, 32'd0, 1'b0, 1'b0, 1'b0, 32'd300000, 32'd1048576},
        '{MODE_CONST, 5'd1,  32'd300000, 32'd10, 32'd0, 1'b0, 1'b0, 1'b1, 32'd300000, 32'd1048576},
        '{MODE_CONST, 5'd1, -32'sd1000000, 32'd10, 32'd0, 1'b1, 1'b0, 1'b0,
          -32'sd1000000, 32'd48576},
        '{MODE_CONST, 5'd1, -32'sd1000000, 32'd10, 32'd0, 1'b0, 1'b0, 1'b0,
          -32'sd1000000, -32'sd951424},
        '{MODE_CONST, 5'd1, -32'sd1000000, 32'd10, 32'd0, 1'b0, 1'b0, 1'b0,
          -32'sd1000000, -32'sd1048576},
        '{MODE_OFF,   5'd1,  32'd0, 32'd0, 32'd0, 1'b1, 1'b0, 1'b0, 32'd0, -32'sd1048576},
        // Extreme inputs saturate the error.
        '{MODE_FB, 5'd20, 32'd0, 32'h7fff_ffff, 32'h8000_0000, 1'b1, 1'b0, 1'b0,
          32'd2047, -32'sd1046529},
        '{MODE_FB, 5'd20, 32'd0, 32'h8000_0000, 32'h7fff_ffff, 1'b1, 1'b0, 1'b0,
          -32'sd1, -32'sd1046530},
        '{MODE_OFF,   5'd20, 32'd0, 32'd0, 32'd0, 1'b1, 1'b0, 1'b0, 32'd0, -32'sd1046530},
        '{MODE_FB,    5'd3,  32'd0, 32'd0, 32'd0, 1'b1, 1'b1, 1'b0, 32'd0, 32'd0},
        '{MODE_FB,    5'd3,  32'd0, 32'd0, 32'd0, 1'b0, 1'b1, 1'b0, 32'd0, 32'd0},
        '{MODE_FB,    5'd3,  32'd0, 32'd0, 32'd0, 1'b0, 1'b1, 1'b1, 32'd0, 32'd0},
        '{MODE_FB,    5'd3,  32'd0, 32'd0, 32'd0, 1'b0, 1'b1, 1'b0, 32'd0, 32'd0},
        '{MODE_FB,    5'd3,  32'd0, 32'd0, 32'd0, 1'b0, 1'b1, 1'b0, 32'd0, 32'd0},
        '{MODE_FB,    5'd3,  32'd0, 32'd0, 32'd0, 1'b0, 1'b1, 1'b0, 32'd0, 32'd0},
        '{MODE_FB,    5'd3,  32'd0, 32'd0, 32'd0, 1'b0, 1'b1, 1'b0, 32'd0, 32'd0},
        '{MODE_FB,    5'd3,  32'd0, 32'd0, 32'd0, 1'b0, 1'b1, 1'b0, 32'd0, 32'd0}
    };

    logic                     clk;
    logic                     rst_n;
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    logic [ADDR_W-1:0]        paddr;
    logic [DATA_W-1:0]        pwdata;
    logic [DATA_W-1:0]        prdata;
    logic                     pready;
    logic                     sample;
    logic signed [DATA_W-1:0] meas;
    logic signed [DATA_W-1:0] step;
    logic signed [DATA_W-1:0] pos;
    logic                     busy;
    logic                     done;
    int                       chk_ok;
    int                       chk_err;
    int                       fails;
    int                       rb_bad;
    logic [31:0]              seed;

    servo_clk_gen clk_gen_i (.o_clk(clk), .o_rst_n(rst_n));

    servo_top dut_i (
        .i_clk(clk), .i_rst_n(rst_n),
        .i_psel(psel), .i_penable(penable), .i_pwrite(pwrite),
        .i_paddr(paddr), .i_pwdata(pwdata), .o_prdata(prdata), .o_pready(pready),
        .i_sample(sample), .i_meas(meas),
        .o_step(step), .o_pos(pos), .o_busy(busy), .o_done(done)
    );

    servo_checker chk_i (
        .i_clk(clk), .i_rst_n(rst_n),
        .i_psel(psel), .i_penable(penable), .i_pwrite(pwrite),
        .i_paddr(paddr), .i_pwdata(pwdata), .i_sample(sample), .i_meas(meas),
        .i_step(step), .i_pos(pos), .i_busy(busy), .i_done(done),
        .o_n_ok(chk_ok), .o_n_err(chk_err)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        @(posedge clk);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= 1'b1;
        paddr <= addr;
        pwdata <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic check_read(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] exp,
                              input string name);
        @(posedge clk);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= 1'b0;
        paddr <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);   // Access cycle ends here.
        if (prdata !== exp) begin
            $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, prdata);
            rb_bad = rb_bad + 1;
        end
        if (pready !== 1'b1) begin
            $display("mismatch at %0t: o_pready expected 1 actual %b", $time, pready);
            rb_bad = rb_bad + 1;
        end
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic run_row(input int r);
        row_t rw;
        logic [31:0] m;
        int err_before;
        bit bad;
        rw = ROWS[r];
        m = rw.meas;
        bad = 1'b0;
        err_before = chk_err;
        if (rw.rnd) begin
            seed = lcg_next(seed);
            m = {{16{seed[31]}}, seed[31:16]};
        end
        if (rw.wr) begin
            apb_write(ADDR_MODE, {30'd0, rw.mode});
            apb_write(ADDR_GAIN, {27'd0, rw.gain});
            apb_write(ADDR_CONST, rw.cst);
            apb_write(ADDR_SETPT, rw.setpt);
        end
        @(posedge clk);
        sample <= 1'b1;
        meas <= m;
        @(posedge clk);
        sample <= 1'b0;
        if (rw.dbl) begin
            @(posedge clk);
            sample <= 1'b1;   // Lands in ST_APPLY.
            meas <= m + 32'd999;
            @(posedge clk);
            sample <= 1'b0;
        end
        @(posedge clk);
        while (!done) @(posedge clk);
        if (!rw.rnd && step !== rw.exp_step) begin
            $display("mismatch at %0t: o_step expected %0d actual %0d",
                     $time, $signed(rw.exp_step), step);
            bad = 1'b1;
        end
        if (!rw.rnd && pos !== rw.exp_pos) begin
            $display("mismatch at %0t: o_pos expected %0d actual %0d",
                     $time, $signed(rw.exp_pos), pos);
            bad = 1'b1;
        end
        @(negedge clk);
        if (chk_err != err_before) bad = 1'b1;
        if (bad) fails = fails + 1;
        $display("test %0d mode %0d meas %0d: step %0d pos %0d, %s",
                 r + 1, rw.mode, $signed(m), step, pos, bad ? "failed" : "ok");
    endtask

    initial begin
        psel <= 1'b0;
        penable <= 1'b0;
        pwrite <= 1'b0;
        paddr <= '0;
        pwdata <= '0;
        sample <= 1'b0;
        meas <= '0;
        fails = 0;
        rb_bad = 0;
        seed = 32'hd95;
        @(posedge rst_n);
        @(posedge clk);
        check_read(ADDR_MODE, 32'd0, "mode");
        check_read(ADDR_GAIN, {27'd0, GAIN_RST}, "gain");
        apb_write(ADDR_GAIN, 32'd7);
        apb_write(ADDR_CONST, 32'h1234_5678);
        apb_write(ADDR_SETPT, 32'hffff_fffb);
        apb_write(ADDR_MODE, 32'd3);
        check_read(ADDR_GAIN, 32'd7, "gain");
        check_read(ADDR_CONST, 32'h1234_5678, "const_step");
        check_read(ADDR_SETPT, 32'hffff_fffb, "setpoint");
        check_read(ADDR_MODE, 32'd3, "mode");
        check_read(5'h10, 32'd0, "unmapped 0x10");
        @(negedge clk);
        if (rb_bad != 0) fails = fails + 1;
        $display("test 0 register readback: %s", (rb_bad != 0) ? "failed" : "ok");
        for (int r = 0; r < NR; r++) begin
            run_row(r);
        end
        $display("tests %0d, failed %0d, model compares ok %0d, model errors %0d",
                 NR + 1, fails, chk_ok, chk_err);
        if (fails == 0 && chk_err == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Watchdog.
    initial begin
        #(WDOG_CYC * CLK_NS);
        $display("timeout: simulation timed out waiting for o_done");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: build.f
hw/servo_pkg.sv
hw/servo_seq_if.sv
hw/servo_ctrl.sv
hw/servo_err.sv
hw/servo_step_gen.sv
hw/servo_actuator.sv
hw/servo_top.sv
dv/servo_clk_gen.sv
dv/servo_checker.sv
dv/servo_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module servo_tb -f build.f -o servo_sim

out=$(./obj_dir/servo_sim)
echo "$out"
if echo "$out" | grep -q "ALL CHECKS PASSED"; then
    exit 0
else
    exit 1
fi
